//--- common/egress_cfg_pkg.sv
//////////////////////////////////////////////////////////////////////
// Egress data path constants
// Port count, bus widths, buffer depth and packet limit
//////////////////////////////////////////////////////////////////////

package egress_cfg_pkg;

    // Port fan-out
    localparam int NUM_PORTS = 4;
    localparam int PORT_SEL_W = 2;

    // Wide input beat and narrow output word, in bytes
    localparam int BUS_BYTES = 8;
    localparam int PORT_BYTES = 2;
    localparam int WORDS_PER_BEAT = BUS_BYTES / PORT_BYTES;

    // Buffer entries per port, counted in input beats
    localparam int FIFO_DEPTH = 16;

    // Longest legal packet, also the space needed to accept one
    localparam int MAX_PKT_BEATS = 8;

    // Statistics counters
    localparam int CNT_W = 32;

endpackage

//--- common/egress_regs_pkg.sv
//////////////////////////////////////////////////////////////////////
// Egress register map for the Wishbone register block
//////////////////////////////////////////////////////////////////////

package egress_regs_pkg;

    localparam int WB_ADR_W = 8;
    localparam int WB_DAT_W = 32;

    // Word addresses
    localparam logic [WB_ADR_W-1:0] REG_ENABLE = 8'h00;
    localparam logic [WB_ADR_W-1:0] REG_CLEAR = 8'h01;

    // Counter block, four words per port
    localparam logic [WB_ADR_W-1:0] REG_CNT_BASE = 8'h10;

    // Counter index within a port
    localparam logic [1:0] CNT_ACCEPTED = 2'd0;
    localparam logic [1:0] CNT_DROP_DISABLED = 2'd1;
    localparam logic [1:0] CNT_DROP_FULL = 2'd2;
    localparam int NUM_CNTS = 3;

endpackage

//--- logic/egress_port_demux.sv
//////////////////////////////////////////////////////////////////////
// Egress demux, registers each input beat and steers it to one port
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module egress_port_demux (
    input  logic                                     clk,
    input  logic                                     rst,
    input  logic                                     in_valid,
    output logic                                     in_ready,
    input  logic [egress_cfg_pkg::BUS_BYTES*8-1:0]   in_data,
    input  logic [egress_cfg_pkg::BUS_BYTES-1:0]     in_keep,
    input  logic                                     in_last,
    input  logic [egress_cfg_pkg::PORT_SEL_W-1:0]    in_port,
    output logic [egress_cfg_pkg::NUM_PORTS-1:0]     port_valid,
    output logic [egress_cfg_pkg::BUS_BYTES*8-1:0]   port_data,
    output logic [egress_cfg_pkg::BUS_BYTES-1:0]     port_keep,
    output logic                                     port_last
);

    logic                                  accept;
    logic                                  mid_pkt;
    logic [egress_cfg_pkg::PORT_SEL_W-1:0] pkt_port;

    assign accept = in_valid && in_ready;

    // Never back-pressured, ports drop instead
    always_ff @(posedge clk) begin
        if (rst) begin
            in_ready <= 1'b0;
            port_valid <= '0;
            mid_pkt <= 1'b0;
        end else begin
            in_ready <= 1'b1;
            for (int p = 0; p < egress_cfg_pkg::NUM_PORTS; p++) begin
                port_valid[p] <= accept && (int'(in_port) == p);
            end
            if (accept) begin
                mid_pkt <= !in_last;
            end
        end
    end

    // Shared beat payload
    always_ff @(posedge clk) begin
        if (accept) begin
            port_data <= in_data;
            port_keep <= in_keep;
            port_last <= in_last;
            pkt_port <= in_port;
        end
    end

    // Destination is fixed for the whole packet
    a_port_stable: assert property (@(posedge clk) disable iff (rst)
        accept && mid_pkt |-> in_port == pkt_port);

endmodule

//--- egress_port/egress_port.sv
//////////////////////////////////////////////////////////////////////
// Egress port, whole-packet drop, beat buffer, 64 to 16 bit narrowing
// and per-port statistics
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module egress_port (
    input  logic                                     clk,
    input  logic                                     rst,
    input  logic                                     enable,
    input  logic                                     cnt_clear,
    input  logic                                     beat_valid,
    input  logic [egress_cfg_pkg::BUS_BYTES*8-1:0]   beat_data,
    input  logic [egress_cfg_pkg::BUS_BYTES-1:0]     beat_keep,
    input  logic                                     beat_last,
    output logic                                     out_valid,
    input  logic                                     out_ready,
    output logic [egress_cfg_pkg::PORT_BYTES*8-1:0]  out_data,
    output logic [egress_cfg_pkg::PORT_BYTES-1:0]    out_keep,
    output logic                                     out_last,
    output logic                                     drop_full,
    output logic [egress_cfg_pkg::CNT_W-1:0]         cnt_accepted,
    output logic [egress_cfg_pkg::CNT_W-1:0]         cnt_drop_disabled,
    output logic [egress_cfg_pkg::CNT_W-1:0]         cnt_drop_full
);

    localparam int DATA_W = egress_cfg_pkg::BUS_BYTES * 8;
    localparam int WORD_W = egress_cfg_pkg::PORT_BYTES * 8;
    localparam int DEPTH = egress_cfg_pkg::FIFO_DEPTH;
    localparam int MAX_BEATS = egress_cfg_pkg::MAX_PKT_BEATS;
    localparam int PTR_W = $clog2(DEPTH);
    localparam int IDX_W = $clog2(egress_cfg_pkg::WORDS_PER_BEAT);

    logic [DATA_W-1:0]                    mem_data [DEPTH];
    logic [egress_cfg_pkg::BUS_BYTES-1:0] mem_keep [DEPTH];
    logic                                 mem_last [DEPTH];
    logic [PTR_W-1:0]                     wr_ptr;
    logic [PTR_W-1:0]                     rd_ptr;
    logic [PTR_W:0]                       count;
    logic [$clog2(MAX_BEATS+1)-1:0]       pkt_beats;
    logic                                 sop;
    logic                                 has_room;
    logic                                 keep_pkt;
    logic                                 wr_en;
    logic                                 rd_en;

    logic                                 hold_valid;
    logic [DATA_W-1:0]                    hold_data;
    logic [egress_cfg_pkg::BUS_BYTES-1:0] hold_keep;
    logic                                 hold_last;
    logic [IDX_W-1:0]                     idx;
    logic [egress_cfg_pkg::WORDS_PER_BEAT-1:0] chunk_valid;
    logic                                 last_chunk;

    //////////////////////////////////////////////////////////////////////
    // Drop decision, taken on the first beat and held for the packet

    assign sop = beat_valid && (pkt_beats == '0);
    assign has_room = int'(count) <= DEPTH - MAX_BEATS;
    assign wr_en = beat_valid && (sop ? (enable && has_room) : keep_pkt);

    always_ff @(posedge clk) begin
        if (rst) begin
            pkt_beats <= '0;
            keep_pkt <= 1'b0;
            drop_full <= 1'b0;
        end else begin
            drop_full <= sop && enable && !has_room;
            if (beat_valid) begin
                pkt_beats <= beat_last ? '0 : pkt_beats + 1'b1;
            end
            if (sop) begin
                keep_pkt <= enable && has_room;
            end
        end
    end

    // Counters, clear wins over a same-cycle packet
    always_ff @(posedge clk) begin
        if (rst || cnt_clear) begin
            cnt_accepted <= '0;
            cnt_drop_disabled <= '0;
            cnt_drop_full <= '0;
        end else if (sop) begin
            if (!enable) begin
                cnt_drop_disabled <= cnt_drop_disabled + 1'b1;
            end else if (!has_room) begin
                cnt_drop_full <= cnt_drop_full + 1'b1;
            end else begin
                cnt_accepted <= cnt_accepted + 1'b1;
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Beat buffer

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem_data[wr_ptr] <= beat_data;
            mem_keep[wr_ptr] <= beat_keep;
            mem_last[wr_ptr] <= beat_last;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count <= '0;
        end else begin
            if (wr_en) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (rd_en) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            count <= count + (PTR_W+1)'(wr_en) - (PTR_W+1)'(rd_en);
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Narrowing, one 16-bit chunk per cycle while out_ready

    // Keep fills from byte 0, so a chunk is live when its low byte is
    always_comb begin
        for (int i = 0; i < egress_cfg_pkg::WORDS_PER_BEAT; i++) begin
            chunk_valid[i] = hold_keep[i*egress_cfg_pkg::PORT_BYTES];
        end
    end

    assign last_chunk = (chunk_valid >> (int'(idx) + 1)) == '0;
    assign rd_en = (count != '0) && (!hold_valid || (out_ready && last_chunk));

    always_ff @(posedge clk) begin
        if (rst) begin
            hold_valid <= 1'b0;
            idx <= '0;
        end else if (rd_en) begin
            hold_valid <= 1'b1;
            idx <= '0;
        end else if (hold_valid && out_ready) begin
            hold_valid <= !last_chunk;
            idx <= last_chunk ? '0 : idx + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rd_en) begin
            hold_data <= mem_data[rd_ptr];
            hold_keep <= mem_keep[rd_ptr];
            hold_last <= mem_last[rd_ptr];
        end
    end

    assign out_valid = hold_valid;
    assign out_data = hold_data[idx*WORD_W +: WORD_W];
    assign out_keep = hold_keep[idx*egress_cfg_pkg::PORT_BYTES +: egress_cfg_pkg::PORT_BYTES];
    assign out_last = hold_last && last_chunk;

    a_no_overflow: assert property (@(posedge clk) disable iff (rst)
        wr_en && !rd_en |-> int'(count) < DEPTH);

    a_pkt_len: assert property (@(posedge clk) disable iff (rst)
        beat_valid |-> int'(pkt_beats) < MAX_BEATS);

endmodule

//--- logic/egress_csr.sv
//////////////////////////////////////////////////////////////////////
// Egress register block
// Wishbone classic slave for port enables, counter clears and readout
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module egress_csr (
    input  logic                                   clk,
    input  logic                                   rst,
    input  logic                                   wb_cyc,
    input  logic                                   wb_stb,
    input  logic                                   wb_we,
    input  logic [egress_regs_pkg::WB_ADR_W-1:0]   wb_adr,
    input  logic [egress_regs_pkg::WB_DAT_W-1:0]   wb_dat_w,
    output logic [egress_regs_pkg::WB_DAT_W-1:0]   wb_dat_r,
    output logic                                   wb_ack,
    output logic [egress_cfg_pkg::NUM_PORTS-1:0]   ports_enable,
    output logic [egress_cfg_pkg::NUM_PORTS-1:0]   cnts_clear,
    input  logic [egress_cfg_pkg::CNT_W-1:0]       cnt_accepted [egress_cfg_pkg::NUM_PORTS],
    input  logic [egress_cfg_pkg::CNT_W-1:0]       cnt_drop_disabled [egress_cfg_pkg::NUM_PORTS],
    input  logic [egress_cfg_pkg::CNT_W-1:0]       cnt_drop_full [egress_cfg_pkg::NUM_PORTS]
);

    localparam int AW = egress_regs_pkg::WB_ADR_W;
    localparam int DW = egress_regs_pkg::WB_DAT_W;
    localparam int PSW = egress_cfg_pkg::PORT_SEL_W;

    logic          req;
    logic          done;
    logic [AW-1:0] cnt_off;
    logic [1:0]    cnt_idx;
    logic          in_cnt_range;
    logic [DW-1:0] rd_val;

    // One ack per strobe and none again until wb_stb drops
    assign req = wb_cyc && wb_stb && !done;

    // Counter address is base + 4 * port + index
    assign cnt_off = wb_adr - egress_regs_pkg::REG_CNT_BASE;
    assign cnt_idx = cnt_off[1:0];
    assign in_cnt_range = (wb_adr >= egress_regs_pkg::REG_CNT_BASE)
        && (int'(cnt_off[AW-1:2]) < egress_cfg_pkg::NUM_PORTS)
        && (int'(cnt_idx) < egress_regs_pkg::NUM_CNTS);

    always_comb begin
        rd_val = '0;
        if (wb_adr == egress_regs_pkg::REG_ENABLE) begin
            rd_val = DW'(ports_enable);
        end else if (in_cnt_range) begin
            case (cnt_idx)
                egress_regs_pkg::CNT_ACCEPTED:
                    rd_val = DW'(cnt_accepted[cnt_off[2 +: PSW]]);
                egress_regs_pkg::CNT_DROP_DISABLED:
                    rd_val = DW'(cnt_drop_disabled[cnt_off[2 +: PSW]]);
                egress_regs_pkg::CNT_DROP_FULL:
                    rd_val = DW'(cnt_drop_full[cnt_off[2 +: PSW]]);
                default:
                    rd_val = '0;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wb_ack <= 1'b0;
            done <= 1'b0;
            ports_enable <= '0;
            cnts_clear <= '0;
        end else begin
            wb_ack <= req;
            if (!wb_stb) begin
                done <= 1'b0;
            end else if (req) begin
                done <= 1'b1;
            end
            // Clear is a pulse and is not stored
            cnts_clear <= '0;
            if (req && wb_we) begin
                if (wb_adr == egress_regs_pkg::REG_ENABLE) begin
                    ports_enable <= wb_dat_w[egress_cfg_pkg::NUM_PORTS-1:0];
                end
                if (wb_adr == egress_regs_pkg::REG_CLEAR) begin
                    cnts_clear <= wb_dat_w[egress_cfg_pkg::NUM_PORTS-1:0];
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (req && !wb_we) begin
            wb_dat_r <= rd_val;
        end
    end

    a_ack_single: assert property (@(posedge clk) disable iff (rst)
        wb_ack |=> !wb_ack);

endmodule

//--- logic/p4_egress.sv
//////////////////////////////////////////////////////////////////////
// Egress stage top, demux into four narrowing ports plus registers
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module p4_egress (
    input  logic                                     clk,
    input  logic                                     rst,
    input  logic                                     in_valid,
    output logic                                     in_ready,
    input  logic [egress_cfg_pkg::BUS_BYTES*8-1:0]   in_data,
    input  logic [egress_cfg_pkg::BUS_BYTES-1:0]     in_keep,
    input  logic                                     in_last,
    input  logic [egress_cfg_pkg::PORT_SEL_W-1:0]    in_port,
    output logic [egress_cfg_pkg::NUM_PORTS-1:0]     out_valid,
    input  logic [egress_cfg_pkg::NUM_PORTS-1:0]     out_ready,
    output logic [egress_cfg_pkg::NUM_PORTS*egress_cfg_pkg::PORT_BYTES*8-1:0] out_data,
    output logic [egress_cfg_pkg::NUM_PORTS*egress_cfg_pkg::PORT_BYTES-1:0]   out_keep,
    output logic [egress_cfg_pkg::NUM_PORTS-1:0]     out_last,
    output logic [egress_cfg_pkg::NUM_PORTS-1:0]     drop_full,
    input  logic                                     wb_cyc,
    input  logic                                     wb_stb,
    input  logic                                     wb_we,
    input  logic [egress_regs_pkg::WB_ADR_W-1:0]     wb_adr,
    input  logic [egress_regs_pkg::WB_DAT_W-1:0]     wb_dat_w,
    output logic [egress_regs_pkg::WB_DAT_W-1:0]     wb_dat_r,
    output logic                                     wb_ack
);

    localparam int N = egress_cfg_pkg::NUM_PORTS;
    localparam int WORD_W = egress_cfg_pkg::PORT_BYTES * 8;
    localparam int PB = egress_cfg_pkg::PORT_BYTES;

    logic [N-1:0]                             port_valid;
    logic [egress_cfg_pkg::BUS_BYTES*8-1:0]   port_data;
    logic [egress_cfg_pkg::BUS_BYTES-1:0]     port_keep;
    logic                                     port_last;
    logic [N-1:0]                             ports_enable;
    logic [N-1:0]                             cnts_clear;
    logic [egress_cfg_pkg::CNT_W-1:0]         cnt_accepted [N];
    logic [egress_cfg_pkg::CNT_W-1:0]         cnt_drop_disabled [N];
    logic [egress_cfg_pkg::CNT_W-1:0]         cnt_drop_full [N];

    egress_port_demux i_demux (
        .clk        (clk),
        .rst        (rst),
        .in_valid   (in_valid),
        .in_ready   (in_ready),
        .in_data    (in_data),
        .in_keep    (in_keep),
        .in_last    (in_last),
        .in_port    (in_port),
        .port_valid (port_valid),
        .port_data  (port_data),
        .port_keep  (port_keep),
        .port_last  (port_last)
    );

    for (genvar g = 0; g < N; g++) begin : g_port
        egress_port i_port (
            .clk               (clk),
            .rst               (rst),
            .enable            (ports_enable[g]),
            .cnt_clear         (cnts_clear[g]),
            .beat_valid        (port_valid[g]),
            .beat_data         (port_data),
            .beat_keep         (port_keep),
            .beat_last         (port_last),
            .out_valid         (out_valid[g]),
            .out_ready         (out_ready[g]),
            .out_data          (out_data[g*WORD_W +: WORD_W]),
            .out_keep          (out_keep[g*PB +: PB]),
            .out_last          (out_last[g]),
            .drop_full         (drop_full[g]),
            .cnt_accepted      (cnt_accepted[g]),
            .cnt_drop_disabled (cnt_drop_disabled[g]),
            .cnt_drop_full     (cnt_drop_full[g])
        );
    end

    egress_csr i_csr (
        .clk               (clk),
        .rst               (rst),
        .wb_cyc            (wb_cyc),
        .wb_stb            (wb_stb),
        .wb_we             (wb_we),
        .wb_adr            (wb_adr),
        .wb_dat_w          (wb_dat_w),
        .wb_dat_r          (wb_dat_r),
        .wb_ack            (wb_ack),
        .ports_enable      (ports_enable),
        .cnts_clear        (cnts_clear),
        .cnt_accepted      (cnt_accepted),
        .cnt_drop_disabled (cnt_drop_disabled),
        .cnt_drop_full     (cnt_drop_full)
    );

endmodule

//--- test/tb_p4_egress_checks.svh
//////////////////////////////////////////////////////////////////////
// Egress testbench compare tasks and Wishbone bus access tasks
//////////////////////////////////////////////////////////////////////

`ifndef TB_P4_EGRESS_CHECKS_SVH
`define TB_P4_EGRESS_CHECKS_SVH

task automatic check_word(
    input int                                       port,
    input logic [egress_cfg_pkg::PORT_BYTES*8-1:0]  exp_data,
    input logic [egress_cfg_pkg::PORT_BYTES*8-1:0]  got_data,
    input logic [egress_cfg_pkg::PORT_BYTES-1:0]    exp_keep,
    input logic [egress_cfg_pkg::PORT_BYTES-1:0]    got_keep,
    input logic                                     exp_last,
    input logic                                     got_last
);
    if (got_data !== exp_data) begin
        $display("error out_data[%0d]: expected 0x%h, got 0x%h", port, exp_data, got_data);
        err_word++;
    end
    if (got_keep !== exp_keep) begin
        $display("error out_keep[%0d]: expected 0x%h, got 0x%h", port, exp_keep, got_keep);
        err_word++;
    end
    if (got_last !== exp_last) begin
        $display("error out_last[%0d]: expected 0x%h, got 0x%h", port, exp_last, got_last);
        err_word++;
    end
endtask

task automatic check_count(
    input string                             name,
    input logic [egress_cfg_pkg::CNT_W-1:0]  exp_v,
    input logic [egress_cfg_pkg::CNT_W-1:0]  got_v
);
    if (got_v !== exp_v) begin
        $display("error %s: expected 0x%h, got 0x%h", name, exp_v, got_v);
        err_count++;
    end
endtask

task automatic check_flag(input string name, input logic exp_v, input logic got_v);
    if (got_v !== exp_v) begin
        $display("error %s: expected 0x%h, got 0x%h", name, exp_v, got_v);
        err_flag++;
    end
endtask

task automatic check_reg(
    input string                                 name,
    input logic [egress_regs_pkg::WB_DAT_W-1:0]  exp_v,
    input logic [egress_regs_pkg::WB_DAT_W-1:0]  got_v
);
    if (got_v !== exp_v) begin
        $display("error %s: expected 0x%h, got 0x%h", name, exp_v, got_v);
        err_reg++;
    end
endtask

// One classic cycle, strobe held until the single-cycle ack
task automatic wb_access(
    input  logic                                 we,
    input  logic [egress_regs_pkg::WB_ADR_W-1:0] adr,
    input  logic [egress_regs_pkg::WB_DAT_W-1:0] wdat,
    output logic [egress_regs_pkg::WB_DAT_W-1:0] rdat
);
    int cycles;
    cycles = 0;
    rdat = '0;
    @(posedge clk);
    wb_cyc <= 1'b1;
    wb_stb <= 1'b1;
    wb_we <= we;
    wb_adr <= adr;
    wb_dat_w <= wdat;
    do begin
        @(negedge clk);
        cycles++;
    end while (!wb_ack && cycles < WAIT_LIMIT);
    if (wb_ack) begin
        rdat = wb_dat_r;
    end else begin
        $display("Timeout waiting for wb_ack at address 0x%h", adr);
        err_timeout++;
    end
    @(posedge clk);
    wb_cyc <= 1'b0;
    wb_stb <= 1'b0;
    wb_we <= 1'b0;
endtask

task automatic wb_write(
    input logic [egress_regs_pkg::WB_ADR_W-1:0] adr,
    input logic [egress_regs_pkg::WB_DAT_W-1:0] wdat
);
    logic [egress_regs_pkg::WB_DAT_W-1:0] unused_rd;
    wb_access(1'b1, adr, wdat, unused_rd);
endtask

task automatic wb_read(
    input  logic [egress_regs_pkg::WB_ADR_W-1:0] adr,
    output logic [egress_regs_pkg::WB_DAT_W-1:0] rdat
);
    wb_access(1'b0, adr, '0, rdat);
endtask

`endif

//--- test/tb_p4_egress.sv
//////////////////////////////////////////////////////////////////////
// Egress stage testbench with table-driven packets and model queues
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module tb_p4_egress;

    localparam int N = egress_cfg_pkg::NUM_PORTS;
    localparam int BB = egress_cfg_pkg::BUS_BYTES;
    localparam int PB = egress_cfg_pkg::PORT_BYTES;
    localparam int WORD_W = PB * 8;
    localparam int AW = egress_regs_pkg::WB_ADR_W;
    localparam int DW = egress_regs_pkg::WB_DAT_W;
    localparam int CW = egress_cfg_pkg::CNT_W;
    localparam int WAIT_LIMIT = 4000;
    localparam int NUM_STIM = 12;

    typedef struct packed {
        logic [egress_cfg_pkg::PORT_SEL_W-1:0] port;
        logic [7:0]                            len;
        logic [7:0]                            seed;
        logic                                  en;
    } stim_t;

    // Port, length in bytes, data seed, port enabled
    stim_t stim [NUM_STIM] = '{
        '{2'd0, 8'd64, 8'h11, 1'b1}, '{2'd1, 8'd1,  8'h22, 1'b1},
        '{2'd2, 8'd9,  8'h33, 1'b1}, '{2'd3, 8'd17, 8'h44, 1'b1},
        '{2'd2, 8'd30, 8'h55, 1'b0}, '{2'd0, 8'd3,  8'h66, 1'b1},
        '{2'd1, 8'd57, 8'h77, 1'b1}, '{2'd3, 8'd12, 8'h88, 1'b0},
        '{2'd2, 8'd16, 8'h99, 1'b1}, '{2'd0, 8'd40, 8'ha5, 1'b0},
        '{2'd3, 8'd63, 8'h5a, 1'b1}, '{2'd1, 8'd2,  8'hc3, 1'b1}
    };

    logic                    clk;
    logic                    rst;
    logic                    in_valid;
    logic                    in_ready;
    logic [BB*8-1:0]         in_data;
    logic [BB-1:0]           in_keep;
    logic                    in_last;
    logic [egress_cfg_pkg::PORT_SEL_W-1:0] in_port;
    logic [N-1:0]            out_valid;
    logic [N-1:0]            out_ready = '0;
    logic [N*WORD_W-1:0]     out_data;
    logic [N*PB-1:0]         out_keep;
    logic [N-1:0]            out_last;
    logic [N-1:0]            drop_full;
    logic                    wb_cyc;
    logic                    wb_stb;
    logic                    wb_we;
    logic [AW-1:0]           wb_adr;
    logic [DW-1:0]           wb_dat_w;
    logic [DW-1:0]           wb_dat_r;
    logic                    wb_ack;

    // Expected words per port as {last, keep, data}
    logic [WORD_W+PB:0]      model_q [N][$];
    logic [CW-1:0]           exp_acc [N];
    logic [CW-1:0]           exp_dis [N];
    logic [CW-1:0]           exp_full [N];
    logic [N-1:0]            ena;
    logic [N-1:0]            ready_hold;
    int                      full_pulses [N];
    int                      err_word;
    int                      err_count;
    int                      err_flag;
    int                      err_reg;
    int                      err_timeout;
    integer                  seed = 38;

    `include "tb_p4_egress_checks.svh"

    p4_egress i_p4_egress (.*);

    initial begin
        clk = 1'b0;
        forever begin
            #50 clk = ~clk;
        end
    end

    // Random back-pressure with held ports forced low
    always @(posedge clk) begin
        if (rst) begin
            out_ready <= '0;
        end else begin
            out_ready <= N'($random(seed)) & ~ready_hold;
        end
    end

    // Output monitor sampling ahead of the edge that moves a word
    always @(negedge clk) begin : monitor
        logic [WORD_W+PB:0] exp_w;
        if (!rst) begin
            for (int p = 0; p < N; p++) begin
                if (drop_full[p]) begin
                    full_pulses[p]++;
                end
                if (out_valid[p] && out_ready[p]) begin
                    if (model_q[p].size() == 0) begin
                        $display("Unexpected output word 0x%h on port %0d",
                            out_data[p*WORD_W +: WORD_W], p);
                        err_word++;
                    end else begin
                        exp_w = model_q[p].pop_front();
                        check_word(p, exp_w[WORD_W-1:0], out_data[p*WORD_W +: WORD_W],
                            exp_w[WORD_W +: PB], out_keep[p*PB +: PB],
                            exp_w[WORD_W+PB], out_last[p]);
                    end
                end
            end
        end
    end

    function automatic logic [7:0] pkt_byte(input logic [7:0] seed_v, input int i);
        return seed_v + 8'(i * 7);
    endfunction

    task automatic send_packet(input stim_t s, input logic expect_out);
        int          nbeats;
        int          lo;
        int          cycles;
        logic        hi;
        logic [BB*8-1:0] data;
        logic [BB-1:0]   keep;
        nbeats = (int'(s.len) + BB - 1) / BB;
        for (int b = 0; b < nbeats; b++) begin
            data = '0;
            keep = '0;
            for (int k = 0; k < BB; k++) begin
                if (b * BB + k < int'(s.len)) begin
                    data[k*8 +: 8] = pkt_byte(s.seed, b * BB + k);
                    keep[k] = 1'b1;
                end
            end
            // One word per 2-byte chunk that holds a byte of the packet
            for (int c = 0; expect_out && c < BB / PB; c++) begin
                lo = b * BB + c * PB;
                if (lo < int'(s.len)) begin
                    hi = (lo + 1 < int'(s.len));
                    model_q[s.port].push_back({lo + PB >= int'(s.len), hi, 1'b1,
                        hi ? pkt_byte(s.seed, lo + 1) : 8'h00, pkt_byte(s.seed, lo)});
                end
            end
            @(posedge clk);
            in_valid <= 1'b1;
            in_data <= data;
            in_keep <= keep;
            in_last <= (b == nbeats - 1);
            in_port <= s.port;
            cycles = 0;
            do begin
                @(negedge clk);
                cycles++;
            end while (!in_ready && cycles < WAIT_LIMIT);
            if (!in_ready) begin
                $display("Timeout: input beat not accepted for port %0d", s.port);
                err_timeout++;
            end
        end
        @(posedge clk);
        in_valid <= 1'b0;
        in_last <= 1'b0;
    endtask

    task automatic wait_drain();
        int cycles;
        int pending;
        cycles = 0;
        do begin
            @(posedge clk);
            cycles++;
            pending = 0;
            for (int p = 0; p < N; p++) begin
                pending += model_q[p].size();
            end
        end while (pending != 0 && cycles < WAIT_LIMIT);
        if (pending != 0) begin
            $display("Timeout: outputs did not drain, %0d words still expected", pending);
            err_timeout++;
        end
    endtask

    task automatic read_counter(input int p, input logic [1:0] idx,
                                input logic [CW-1:0] exp_v, input string name);
        logic [DW-1:0] rd;
        wb_read(egress_regs_pkg::REG_CNT_BASE + AW'(4 * p) + AW'(idx), rd);
        check_count($sformatf("%s[%0d]", name, p), exp_v, CW'(rd));
    endtask

    task automatic check_counters();
        for (int p = 0; p < N; p++) begin
            read_counter(p, egress_regs_pkg::CNT_ACCEPTED, exp_acc[p], "cnt_accepted");
            read_counter(p, egress_regs_pkg::CNT_DROP_DISABLED, exp_dis[p], "cnt_drop_disabled");
            read_counter(p, egress_regs_pkg::CNT_DROP_FULL, exp_full[p], "cnt_drop_full");
        end
    endtask

    task automatic check_unmapped(input logic [AW-1:0] adr);
        logic [DW-1:0] rd;
        wb_read(adr, rd);
        check_reg($sformatf("reg[0x%h]", adr), '0, rd);
    endtask

    initial begin : main
        logic [DW-1:0] rd;
        int            full_before;
        stim_t         full_pkt;
        rst = 1'b1;
        in_valid = 1'b0;
        in_data = '0;
        in_keep = '0;
        in_last = 1'b0;
        in_port = '0;
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we = 1'b0;
        wb_adr = '0;
        wb_dat_w = '0;
        ena = '0;
        ready_hold = '0;
        for (int p = 0; p < N; p++) begin
            exp_acc[p] = '0;
            exp_dis[p] = '0;
            exp_full[p] = '0;
        end
        repeat (4) @(posedge clk);
        // Outputs idle while reset is held
        @(negedge clk);
        check_flag("in_ready", 1'b0, in_ready);
        check_flag("wb_ack", 1'b0, wb_ack);
        check_flag("out_valid", 1'b0, |out_valid);
        check_flag("drop_full", 1'b0, |drop_full);
        @(posedge clk);
        rst <= 1'b0;

        ////////////////////////////////////////////////////////////////////
        // Routing, narrowing and disabled drops from the table
        for (int i = 0; i < NUM_STIM; i++) begin
            if (ena[stim[i].port] != stim[i].en) begin
                ena[stim[i].port] = stim[i].en;
                wb_write(egress_regs_pkg::REG_ENABLE, DW'(ena));
            end
            full_before = full_pulses[stim[i].port];
            send_packet(stim[i], stim[i].en);
            if (stim[i].en) begin
                exp_acc[stim[i].port] = exp_acc[stim[i].port] + 1'b1;
            end else begin
                exp_dis[stim[i].port] = exp_dis[stim[i].port] + 1'b1;
            end
            wait_drain();
            // Counters settle within 3 cycles
            repeat (4) @(posedge clk);
            check_flag($sformatf("drop_full[%0d]", stim[i].port), 1'b0,
                full_pulses[stim[i].port] != full_before);
        end

        ////////////////////////////////////////////////////////////////////
        // Full drop on port 1 with its output stalled
        ena[1] = 1'b1;
        wb_write(egress_regs_pkg::REG_ENABLE, DW'(ena));
        ready_hold <= N'(2);
        full_before = full_pulses[1];
        for (int k = 0; k < 3; k++) begin
            full_pkt.port = 2'd1;
            full_pkt.len = 8'(egress_cfg_pkg::MAX_PKT_BEATS * BB);
            full_pkt.seed = 8'h30 + 8'(k);
            full_pkt.en = 1'b1;
            send_packet(full_pkt, k < 2);
        end
        exp_acc[1] = exp_acc[1] + 2'd2;
        exp_full[1] = exp_full[1] + 1'b1;
        repeat (4) @(posedge clk);
        check_flag("drop_full[1]", 1'b1, full_pulses[1] != full_before);
        check_count("drop_full pulses[1]", CW'(1), CW'(full_pulses[1] - full_before));
        ready_hold <= '0;
        wait_drain();

        ////////////////////////////////////////////////////////////////////
        // Counter readout, holes in the map, enable readback and clear
        check_counters();
        check_unmapped(8'h02);
        check_unmapped(8'h13);
        check_unmapped(8'h20);
        check_unmapped(8'hff);
        wb_write(egress_regs_pkg::REG_ENABLE, DW'(4'ha));
        wb_read(egress_regs_pkg::REG_ENABLE, rd);
        check_reg("ports_enable", DW'(4'ha), rd);
        wb_write(egress_regs_pkg::REG_CLEAR, DW'(4'b0100));
        wb_read(egress_regs_pkg::REG_CLEAR, rd);
        check_reg("reg_clear", '0, rd);
        exp_acc[2] = '0;
        exp_dis[2] = '0;
        exp_full[2] = '0;
        check_counters();

        $display("Check summary: word %0d, count %0d, flag %0d, register %0d, timeout %0d",
            err_word, err_count, err_flag, err_reg, err_timeout);
        if (err_word + err_count + err_flag + err_reg + err_timeout == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

//--- sources.f
+incdir+test
common/egress_cfg_pkg.sv
common/egress_regs_pkg.sv
logic/egress_port_demux.sv
egress_port/egress_port.sv
logic/egress_csr.sv
logic/p4_egress.sv
test/tb_p4_egress.sv

//--- Makefile
# Verilator build and run for the egress stage testbench

VERILATOR ?= verilator
TOP       ?= tb_p4_egress
RTL_TOP   ?= p4_egress
FILELIST  ?= sources.f
BUILD_DIR ?= obj_dir
JOBS      ?= 0
VFLAGS    ?= --binary --timing --assert -j $(JOBS)
PASS_MSG  ?= >>> PASS

SRCS := $(shell grep -v '^+' $(FILELIST))
HDRS := test/tb_p4_egress_checks.svh
SIM  := $(BUILD_DIR)/V$(TOP)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing -f $(FILELIST) --top-module $(TOP)

$(SIM): $(SRCS) $(HDRS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

sim: $(SIM)
	@out="$$(./$(SIM))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF -- '$(PASS_MSG)'

clean:
	rm -rf $(BUILD_DIR)
